/* include/io_mmio_map_defs.svh */
`ifndef IO_MMIO_MAP_DEFS_SVH
`define IO_MMIO_MAP_DEFS_SVH

// Slot assignment
`define IO_S0_GPO 0
`define IO_S1_DDFS 1
`define IO_S2_ADSR 2
`define IO_NUM_SLOTS 64

// Slot field inside the host address, register offset sits below it
`define IO_SLOT_LSB 5
`define IO_SLOT_MSB 10

`define DDFS_REG_FREQ 5'd0
`define DDFS_REG_PHASE 5'd1
`define DDFS_REG_CTRL 5'd2
`define DDFS_REG_ENV 5'd3

`define ADSR_REG_ATTACK 5'd0
`define ADSR_REG_DECAY 5'd1
`define ADSR_REG_SUSTAIN 5'd2
`define ADSR_REG_RELEASE 5'd3
`define ADSR_REG_CTRL 5'd4
`define ADSR_REG_STATUS 5'd5

// System clocks per serial bit
`define I2S_SCLK_DIV 4

`endif

/* verilog/mmio_pkg.sv */
package mmio_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Audio sample and envelope, 0xffff is full scale
    typedef logic signed [15:0] pcm_t;
    typedef logic [15:0] env_t;

    typedef enum logic [1:0] {
        WAVE_SQUARE   = 2'd0,
        WAVE_SAW      = 2'd1,
        WAVE_TRIANGLE = 2'd2
    } wave_t;

    typedef enum logic [2:0] {
        ADSR_IDLE    = 3'd0,
        ADSR_ATTACK  = 3'd1,
        ADSR_DECAY   = 3'd2,
        ADSR_SUSTAIN = 3'd3,
        ADSR_RELEASE = 3'd4
    } adsr_state_t;

endpackage

/* verilog/mmio_controller.sv */
`timescale 1ns/1ps
`include "io_mmio_map_defs.svh"

module mmio_controller (
    input  logic                             i_mmio_cs,
    input  logic                             i_mmio_write,
    input  logic                             i_mmio_read,
    input  logic [20:0]                      i_mmio_addr,
    input  mmio_pkg::word_t                  i_mmio_write_data,
    output mmio_pkg::word_t                  o_mmio_read_data,
    output logic [`IO_NUM_SLOTS-1:0]         o_slot_cs,
    output logic [`IO_NUM_SLOTS-1:0]         o_slot_read,
    output logic [`IO_NUM_SLOTS-1:0]         o_slot_write,
    output mmio_pkg::reg_addr_t              o_slot_reg_addr,
    output mmio_pkg::word_t                  o_slot_write_data,
    input  mmio_pkg::word_t                  i_slot_read_data [`IO_NUM_SLOTS]
);
    import mmio_pkg::*;

    logic [`IO_SLOT_MSB-`IO_SLOT_LSB:0] slot_sel;

    assign slot_sel = i_mmio_addr[`IO_SLOT_MSB:`IO_SLOT_LSB];

    // One-hot slot select, only while the host drives chip select
    always_comb begin
        o_slot_cs = '0;
        if (i_mmio_cs) begin
            o_slot_cs[slot_sel] = 1'b1;
        end
    end

    assign o_slot_read  = i_mmio_read ? o_slot_cs : '0;
    assign o_slot_write = i_mmio_write ? o_slot_cs : '0;

    // Shared by all slots, only the selected one acts
    assign o_slot_reg_addr   = reg_addr_t'(i_mmio_addr[`IO_SLOT_LSB-1:0]);
    assign o_slot_write_data = i_mmio_write_data;

    assign o_mmio_read_data = i_slot_read_data[slot_sel];

endmodule

/* verilog/mmio_gpo.sv */
`timescale 1ns/1ps

module mmio_gpo (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_cs,
    input  logic                i_read,
    input  logic                i_write,
    input  mmio_pkg::reg_addr_t i_addr,
    input  mmio_pkg::word_t     i_write_data,
    output mmio_pkg::word_t     o_read_data,
    output mmio_pkg::word_t     o_gpo
);
    import mmio_pkg::*;

    word_t gpo_q;
    logic  sel_data;

    // Single data register at offset 0
    assign sel_data = (i_addr == 5'd0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            gpo_q <= '0;
        end else if (i_cs && i_write && sel_data) begin
            gpo_q <= i_write_data;
        end
    end

    assign o_read_data = (i_cs && i_read && sel_data) ? gpo_q : '0;
    assign o_gpo       = gpo_q;

endmodule

/* verilog/mmio_ddfs.sv */
`timescale 1ns/1ps
`include "io_mmio_map_defs.svh"

module mmio_ddfs (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_cs,
    input  logic                i_read,
    input  logic                i_write,
    input  mmio_pkg::reg_addr_t i_addr,
    input  mmio_pkg::word_t     i_write_data,
    output mmio_pkg::word_t     o_read_data,
    input  logic                i_en,
    input  mmio_pkg::env_t      i_env_ext,
    output mmio_pkg::pcm_t      o_pcm_out,
    output logic                o_data_valid
);
    import mmio_pkg::*;

    logic [23:0]        freq_q;
    logic [23:0]        phase_ofs_q;
    wave_t              wave_sel_q;
    logic               env_src_q;
    env_t               env_q;

    logic [23:0]        phase_acc;
    logic [23:0]        phase_sum;
    logic [15:0]        p;
    logic [14:0]        tri_u;
    logic signed [16:0] tri_w;
    pcm_t               wave;
    env_t               env_used;
    logic signed [32:0] product;
    pcm_t               pcm_q;
    logic               valid_q;
    logic               wr_en;

    assign wr_en = i_cs && i_write;

    // Register file
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            freq_q      <= '0;
            phase_ofs_q <= '0;
            wave_sel_q  <= WAVE_SQUARE;
            env_src_q   <= 1'b0;
            env_q       <= '0;
        end else if (wr_en) begin
            case (i_addr)
                `DDFS_REG_FREQ:  freq_q <= i_write_data[23:0];
                `DDFS_REG_PHASE: phase_ofs_q <= i_write_data[23:0];
                `DDFS_REG_CTRL: begin
                    wave_sel_q <= wave_t'(i_write_data[1:0]);
                    env_src_q  <= i_write_data[2];
                end
                `DDFS_REG_ENV:   env_q <= i_write_data[15:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        o_read_data = '0;
        if (i_cs && i_read) begin
            case (i_addr)
                `DDFS_REG_FREQ:  o_read_data = {8'h00, freq_q};
                `DDFS_REG_PHASE: o_read_data = {8'h00, phase_ofs_q};
                `DDFS_REG_CTRL:  o_read_data = {29'h0, env_src_q, wave_sel_q};
                `DDFS_REG_ENV:   o_read_data = {16'h0, env_q};
                default:         o_read_data = '0;
            endcase
        end
    end

    // Waveform from the offset phase
    assign phase_sum = phase_acc + phase_ofs_q;
    assign p         = phase_sum[23:8];
    assign tri_u     = p[15] ? ~p[14:0] : p[14:0];
    assign tri_w     = $signed({1'b0, tri_u, 1'b0}) - 17'sd32767;

    always_comb begin
        case (wave_sel_q)
            WAVE_SQUARE:   wave = p[15] ? 16'sh8001 : 16'sh7fff;
            WAVE_SAW:      wave = $signed(p);
            WAVE_TRIANGLE: wave = tri_w[15:0];
            default:       wave = '0;
        endcase
    end

    assign env_used = env_src_q ? i_env_ext : env_q;
    // Q16 scaling, the slice is the arithmetic shift by 16
    assign product  = wave * $signed({1'b0, env_used});

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase_acc <= '0;
            pcm_q     <= '0;
            valid_q   <= 1'b0;
        end else if (i_en) begin
            pcm_q     <= product[31:16];
            phase_acc <= phase_acc + freq_q;
            valid_q   <= 1'b1;
        end
    end

    assign o_pcm_out    = pcm_q;
    assign o_data_valid = valid_q;

endmodule

/* verilog/mmio_adsr.sv */
`timescale 1ns/1ps
`include "io_mmio_map_defs.svh"

module mmio_adsr (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_cs,
    input  logic                i_read,
    input  logic                i_write,
    input  mmio_pkg::reg_addr_t i_addr,
    input  mmio_pkg::word_t     i_write_data,
    output mmio_pkg::word_t     o_read_data,
    output mmio_pkg::env_t      o_env
);
    import mmio_pkg::*;

    word_t       attack_step_q;
    word_t       decay_step_q;
    word_t       release_step_q;
    env_t        sustain_q;
    logic        gate_q;

    adsr_state_t state;
    word_t       acc;
    logic [32:0] att_sum;
    logic [32:0] dec_diff;
    logic [32:0] rel_diff;
    word_t       sus_target;
    logic        wr_en;
    logic        ctrl_wr;

    assign wr_en   = i_cs && i_write;
    assign ctrl_wr = wr_en && (i_addr == `ADSR_REG_CTRL);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            attack_step_q  <= '0;
            decay_step_q   <= '0;
            release_step_q <= '0;
            sustain_q      <= '0;
            gate_q         <= 1'b0;
        end else if (wr_en) begin
            case (i_addr)
                `ADSR_REG_ATTACK:  attack_step_q <= i_write_data;
                `ADSR_REG_DECAY:   decay_step_q <= i_write_data;
                `ADSR_REG_SUSTAIN: sustain_q <= i_write_data[15:0];
                `ADSR_REG_RELEASE: release_step_q <= i_write_data;
                `ADSR_REG_CTRL:    gate_q <= i_write_data[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        o_read_data = '0;
        if (i_cs && i_read) begin
            case (i_addr)
                `ADSR_REG_ATTACK:  o_read_data = attack_step_q;
                `ADSR_REG_DECAY:   o_read_data = decay_step_q;
                `ADSR_REG_SUSTAIN: o_read_data = {16'h0, sustain_q};
                `ADSR_REG_RELEASE: o_read_data = release_step_q;
                `ADSR_REG_CTRL:    o_read_data = {31'h0, gate_q};
                `ADSR_REG_STATUS:  o_read_data = {acc[31:16], 13'h0, state};
                default:           o_read_data = '0;
            endcase
        end
    end

    // Extra top bit catches overflow and underflow of each step
    assign att_sum    = {1'b0, acc} + {1'b0, attack_step_q};
    assign dec_diff   = {1'b0, acc} - {1'b0, decay_step_q};
    assign rel_diff   = {1'b0, acc} - {1'b0, release_step_q};
    assign sus_target = {sustain_q, 16'h0000};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= ADSR_IDLE;
            acc   <= '0;
        end else if (ctrl_wr && i_write_data[0]) begin
            // Retrigger starts from the current level
            state <= ADSR_ATTACK;
        end else if (ctrl_wr && (state != ADSR_IDLE)) begin
            state <= ADSR_RELEASE;
        end else begin
            case (state)
                ADSR_ATTACK: begin
                    if (att_sum[32] || (&att_sum[31:0])) begin
                        acc   <= '1;
                        state <= ADSR_DECAY;
                    end else begin
                        acc <= att_sum[31:0];
                    end
                end
                ADSR_DECAY: begin
                    if (dec_diff[32] || (dec_diff[31:0] <= sus_target)) begin
                        acc   <= sus_target;
                        state <= ADSR_SUSTAIN;
                    end else begin
                        acc <= dec_diff[31:0];
                    end
                end
                ADSR_SUSTAIN: acc <= sus_target;
                ADSR_RELEASE: begin
                    if (rel_diff[32] || (rel_diff[31:0] == '0)) begin
                        acc   <= '0;
                        state <= ADSR_IDLE;
                    end else begin
                        acc <= rel_diff[31:0];
                    end
                end
                default: acc <= '0;
            endcase
        end
    end

    assign o_env = acc[31:16];

endmodule

/* verilog/i2s_tx.sv */
`timescale 1ns/1ps
`include "io_mmio_map_defs.svh"

module i2s_tx (
    input  logic           i_clk,
    input  logic           i_reset,
    input  mmio_pkg::pcm_t i_audio_l,
    input  mmio_pkg::pcm_t i_audio_r,
    input  logic           i_data_valid,
    output logic           o_data_ready,
    output logic           o_tx_mclk,
    output logic           o_tx_sclk,
    output logic           o_tx_lrclk,
    output logic           o_tx_sd
);
    import mmio_pkg::*;

    localparam int DIV   = `I2S_SCLK_DIV;
    localparam int DIV_W = $clog2(DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             bit_tick;
    logic [4:0]       bit_cnt;
    logic [4:0]       next_bit;
    word_t            shift_q;
    word_t            frame_word;

    // Falling sclk edge, one per serial bit
    assign bit_tick = (div_cnt == DIV_W'(DIV - 1));
    assign next_bit = bit_cnt + 5'd1;

    // Left word in the upper half, silence until the DDFS has a sample
    assign frame_word = i_data_valid ? {i_audio_l, i_audio_r} : '0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            div_cnt      <= '0;
            o_tx_mclk    <= 1'b0;
            o_tx_sclk    <= 1'b0;
            o_data_ready <= 1'b0;
        end else begin
            o_tx_mclk <= ~o_tx_mclk;
            div_cnt   <= bit_tick ? '0 : div_cnt + 1'b1;
            if (div_cnt == DIV_W'(DIV / 2 - 1)) begin
                o_tx_sclk <= 1'b1;
            end else if (bit_tick) begin
                o_tx_sclk <= 1'b0;
            end
            // High in the cycle before the frame load
            o_data_ready <= (div_cnt == DIV_W'(DIV - 2)) && (bit_cnt == 5'd31);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bit_cnt    <= '0;
            shift_q    <= '0;
            o_tx_lrclk <= 1'b0;
            o_tx_sd    <= 1'b0;
        end else if (bit_tick) begin
            bit_cnt    <= next_bit;
            o_tx_lrclk <= next_bit[4];
            if (next_bit == 5'd0) begin
                o_tx_sd <= frame_word[31];
                shift_q <= {frame_word[30:0], 1'b0};
            end else begin
                o_tx_sd <= shift_q[31];
                shift_q <= {shift_q[30:0], 1'b0};
            end
        end
    end

endmodule

/* verilog/mmio_top.sv */
`timescale 1ns/1ps
`include "io_mmio_map_defs.svh"

module mmio_top (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_mmio_cs,
    input  logic            i_mmio_write,
    input  logic            i_mmio_read,
    input  logic [20:0]     i_mmio_addr,
    input  mmio_pkg::word_t i_mmio_write_data,
    output mmio_pkg::word_t o_mmio_read_data,
    output logic [3:0]      o_led,
    output logic            o_audio_tx_mclk,
    output logic            o_audio_tx_sclk,
    output logic            o_audio_tx_lrclk,
    output logic            o_audio_tx_sd
);
    import mmio_pkg::*;

    logic [`IO_NUM_SLOTS-1:0] slot_cs;
    logic [`IO_NUM_SLOTS-1:0] slot_read;
    logic [`IO_NUM_SLOTS-1:0] slot_write;
    reg_addr_t                slot_reg_addr;
    word_t                    slot_write_data;
    word_t                    slot_read_data [`IO_NUM_SLOTS];

    word_t gpo;
    logic  ddfs_en;
    logic  ddfs_data_valid;
    pcm_t  ddfs_pcm;
    env_t  adsr_env;

    mmio_controller mmio_controller_unit (
        .i_mmio_cs         (i_mmio_cs),
        .i_mmio_write      (i_mmio_write),
        .i_mmio_read       (i_mmio_read),
        .i_mmio_addr       (i_mmio_addr),
        .i_mmio_write_data (i_mmio_write_data),
        .o_mmio_read_data  (o_mmio_read_data),
        .o_slot_cs         (slot_cs),
        .o_slot_read       (slot_read),
        .o_slot_write      (slot_write),
        .o_slot_reg_addr   (slot_reg_addr),
        .o_slot_write_data (slot_write_data),
        .i_slot_read_data  (slot_read_data)
    );

    mmio_gpo mmio_gpo_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_cs         (slot_cs[`IO_S0_GPO]),
        .i_read       (slot_read[`IO_S0_GPO]),
        .i_write      (slot_write[`IO_S0_GPO]),
        .i_addr       (slot_reg_addr),
        .i_write_data (slot_write_data),
        .o_read_data  (slot_read_data[`IO_S0_GPO]),
        .o_gpo        (gpo)
    );

    assign o_led = gpo[3:0];

    mmio_ddfs mmio_ddfs_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_cs         (slot_cs[`IO_S1_DDFS]),
        .i_read       (slot_read[`IO_S1_DDFS]),
        .i_write      (slot_write[`IO_S1_DDFS]),
        .i_addr       (slot_reg_addr),
        .i_write_data (slot_write_data),
        .o_read_data  (slot_read_data[`IO_S1_DDFS]),
        .i_en         (ddfs_en),
        .i_env_ext    (adsr_env),
        .o_pcm_out    (ddfs_pcm),
        .o_data_valid (ddfs_data_valid)
    );

    mmio_adsr mmio_adsr_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_cs         (slot_cs[`IO_S2_ADSR]),
        .i_read       (slot_read[`IO_S2_ADSR]),
        .i_write      (slot_write[`IO_S2_ADSR]),
        .i_addr       (slot_reg_addr),
        .i_write_data (slot_write_data),
        .o_read_data  (slot_read_data[`IO_S2_ADSR]),
        .o_env        (adsr_env)
    );

    // Mono source on both channels
    i2s_tx i2s_tx_unit (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_audio_l    (ddfs_pcm),
        .i_audio_r    (ddfs_pcm),
        .i_data_valid (ddfs_data_valid),
        .o_data_ready (ddfs_en),
        .o_tx_mclk    (o_audio_tx_mclk),
        .o_tx_sclk    (o_audio_tx_sclk),
        .o_tx_lrclk   (o_audio_tx_lrclk),
        .o_tx_sd      (o_audio_tx_sd)
    );

    // Empty slots read as all ones
    for (genvar i = 3; i < `IO_NUM_SLOTS; i++) begin : g_unused_slot
        assign slot_read_data[i] = 32'hffff_ffff;
    end

endmodule

/* tb/mmio_top_tb.sv */
`timescale 1ns/1ps
`include "io_mmio_map_defs.svh"

module mmio_top_tb;
    import mmio_pkg::*;

    localparam int CLK_PERIOD = 40;
    // Roughly 40 frames of 128 clocks plus the ADSR ramps, with margin
    localparam int MAX_CYCLES = 20000;
    localparam int POLL_LIMIT = 1000;

    logic        clk = 1'b0;
    logic        reset;
    logic        mmio_cs;
    logic        mmio_write;
    logic        mmio_read;
    logic [20:0] mmio_addr;
    word_t       mmio_write_data;
    word_t       mmio_read_data;
    logic [3:0]  led;
    logic        tx_mclk;
    logic        tx_sclk;
    logic        tx_lrclk;
    logic        tx_sd;

    string       current_test;
    int          error_count = 0;
    int          errors_at_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          frame_count = 0;
    int          polls;
    word_t       seed_value;
    word_t       value;
    word_t       rd;
    logic [15:0] sustain;
    logic [15:0] prev_env;
    logic        saw_attack;
    logic        saw_decay;

    // Serial capture state
    logic        sclk_prev;
    logic        cap_lr;
    int          cap_bits;
    logic [15:0] cap_shift;
    logic [15:0] left_word;
    logic [15:0] right_word;

    mmio_top uut (
        .i_clk             (clk),
        .i_reset           (reset),
        .i_mmio_cs         (mmio_cs),
        .i_mmio_write      (mmio_write),
        .i_mmio_read       (mmio_read),
        .i_mmio_addr       (mmio_addr),
        .i_mmio_write_data (mmio_write_data),
        .o_mmio_read_data  (mmio_read_data),
        .o_led             (led),
        .o_audio_tx_mclk   (tx_mclk),
        .o_audio_tx_sclk   (tx_sclk),
        .o_audio_tx_lrclk  (tx_lrclk),
        .o_audio_tx_sd     (tx_sd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // One bit per rising sclk, a new word starts when lrclk toggles
    always @(negedge clk) begin
        if (reset) begin
            sclk_prev = 1'b0;
            cap_lr    = 1'b0;
            cap_bits  = 0;
            cap_shift = '0;
        end else begin
            if (tx_sclk && !sclk_prev) begin
                if (tx_lrclk != cap_lr) begin
                    cap_lr   = tx_lrclk;
                    cap_bits = 0;
                end
                cap_shift = {cap_shift[14:0], tx_sd};
                cap_bits++;
                if (cap_bits == 16) begin
                    cap_bits = 0;
                    if (cap_lr) begin
                        right_word = cap_shift;
                        frame_count++;
                    end else begin
                        left_word = cap_shift;
                    end
                end
            end
            sclk_prev = tx_sclk;
        end
    end

    function automatic logic [20:0] slot_addr(input int slot, input reg_addr_t offset);
        return (21'(slot) << `IO_SLOT_LSB) | 21'(offset);
    endfunction

    function automatic logic [15:0] square_wave(input logic [15:0] p);
        return p[15] ? 16'h8001 : 16'h7fff;
    endfunction

    // Waveform times envelope, arithmetic shift right by 16
    function automatic logic [15:0] scaled_sample(input logic [15:0] wave_bits,
                                                  input logic [15:0] env);
        longint prod;
        prod = longint'($signed(wave_bits)) * longint'(env);
        prod = prod >>> 16;
        return prod[15:0];
    endfunction

    task automatic check_equal(input string what, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected 0x%08h, actual 0x%08h",
                     current_test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        int errs;
        errs = error_count - errors_at_start;
        if (errs == 0) begin
            pass_count++;
            $display("%s: pass", current_test);
        end else begin
            fail_count++;
            $display("%s: fail with %0d errors", current_test, errs);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic bus_write(input logic [20:0] addr, input word_t data);
        @(negedge clk);
        mmio_cs         = 1'b1;
        mmio_write      = 1'b1;
        mmio_read       = 1'b0;
        mmio_addr       = addr;
        mmio_write_data = data;
        @(negedge clk);
        mmio_cs    = 1'b0;
        mmio_write = 1'b0;
    endtask

    task automatic bus_read(input logic [20:0] addr, output word_t data);
        @(negedge clk);
        mmio_cs    = 1'b1;
        mmio_read  = 1'b1;
        mmio_write = 1'b0;
        mmio_addr  = addr;
        #(CLK_PERIOD / 4);
        data = mmio_read_data;
        @(negedge clk);
        mmio_cs   = 1'b0;
        mmio_read = 1'b0;
    endtask

    task automatic check_register(input string what, input reg_addr_t offset, input word_t mask);
        word_t data;
        word_t rd_val;
        data = $urandom;
        bus_write(slot_addr(`IO_S1_DDFS, offset), data);
        bus_read(slot_addr(`IO_S1_DDFS, offset), rd_val);
        check_equal(what, data & mask, rd_val);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target) @(posedge clk);
    endtask

    task automatic check_audio(input logic [15:0] expected);
        check_equal("left word", {16'h0, expected}, {16'h0, left_word});
        check_equal("right word", {16'h0, expected}, {16'h0, right_word});
    endtask

    initial begin
        seed_value      = $urandom(32'hd11c);
        reset           = 1'b1;
        mmio_cs         = 1'b0;
        mmio_write      = 1'b0;
        mmio_read       = 1'b0;
        mmio_addr       = '0;
        mmio_write_data = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        start_test("gpo");
        value = $urandom;
        bus_write(slot_addr(`IO_S0_GPO, 5'd0), value);
        bus_read(slot_addr(`IO_S0_GPO, 5'd0), rd);
        check_equal("readback", value, rd);
        check_equal("led", {28'h0, value[3:0]}, {28'h0, led});
        // Address bits above the slot field are ignored
        bus_read(21'h800 | slot_addr(`IO_S0_GPO, 5'd0), rd);
        check_equal("upper address bits", value, rd);
        finish_test();

        start_test("decode");
        bus_read(slot_addr(3, 5'd0), rd);
        check_equal("slot 3", 32'hffff_ffff, rd);
        bus_read(slot_addr(63, 5'd17), rd);
        check_equal("slot 63", 32'hffff_ffff, rd);
        bus_read(slot_addr(`IO_S0_GPO, 5'd1), rd);
        check_equal("gpo offset 1", 32'h0, rd);
        bus_read(slot_addr(`IO_S1_DDFS, 5'd4), rd);
        check_equal("ddfs offset 4", 32'h0, rd);
        bus_read(slot_addr(`IO_S2_ADSR, 5'd31), rd);
        check_equal("adsr offset 31", 32'h0, rd);
        finish_test();

        start_test("ddfs_registers");
        check_register("freq", `DDFS_REG_FREQ, 32'h00ff_ffff);
        check_register("phase", `DDFS_REG_PHASE, 32'h00ff_ffff);
        check_register("ctrl", `DDFS_REG_CTRL, 32'h0000_0007);
        check_register("env", `DDFS_REG_ENV, 32'h0000_ffff);
        finish_test();

        // Fresh phase accumulator for the audio checks
        apply_reset();
        start_test("reset_and_mclk");
        check_equal("led after reset", 32'h0, {28'h0, led});
        check_equal("mclk after reset", 32'h0, {31'h0, tx_mclk});
        check_equal("sclk after reset", 32'h0, {31'h0, tx_sclk});
        check_equal("lrclk after reset", 32'h0, {31'h0, tx_lrclk});
        check_equal("sd after reset", 32'h0, {31'h0, tx_sd});
        // Master clock is the system clock divided by 2
        for (int k = 1; k <= 8; k++) begin
            @(negedge clk);
            check_equal("mclk", word_t'(k % 2), {31'h0, tx_mclk});
        end
        finish_test();

        start_test("audio_square");
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_FREQ), 32'h0);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE), 32'h0);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_ENV), 32'h0000_ffff);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_CTRL), 32'h0);
        wait_frames(3);
        check_audio(scaled_sample(square_wave(16'h0000), 16'hffff));
        finish_test();

        start_test("audio_sawtooth");
        value = $urandom & 32'h00ff_ffff;
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE), value);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_CTRL), 32'h1);
        wait_frames(3);
        check_audio(scaled_sample(value[23:8], 16'hffff));
        finish_test();

        start_test("adsr_envelope");
        sustain = 16'h4000 + 16'($urandom % 32'h8000);
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_ATTACK), 32'h0100_0000);
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_DECAY), 32'h0080_0000);
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_SUSTAIN), {16'h0, sustain});
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_RELEASE), 32'h0100_0000);
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_CTRL), 32'h1);
        saw_attack = 1'b0;
        saw_decay  = 1'b0;
        prev_env   = '0;
        polls      = 0;
        bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS), rd);
        while (rd[2:0] != ADSR_SUSTAIN && polls < POLL_LIMIT) begin
            if (rd[2:0] == ADSR_ATTACK) begin
                saw_attack = 1'b1;
                assert (rd[31:16] >= prev_env) else begin
                    $display("ERROR %s: envelope fell from 0x%04h to 0x%04h during attack",
                             current_test, prev_env, rd[31:16]);
                    error_count++;
                end
                prev_env = rd[31:16];
            end
            if (rd[2:0] == ADSR_DECAY) begin
                saw_decay = 1'b1;
            end
            polls++;
            bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS), rd);
        end
        check_equal("attack seen", 32'h1, {31'h0, saw_attack});
        check_equal("decay seen", 32'h1, {31'h0, saw_decay});
        check_equal("state", {29'h0, ADSR_SUSTAIN}, {29'h0, rd[2:0]});
        check_equal("envelope", {16'h0, sustain}, {16'h0, rd[31:16]});
        finish_test();

        start_test("modulation_sustain");
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE), 32'h0);
        // Square wave scaled by the ADSR output
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_CTRL), 32'h4);
        wait_frames(3);
        check_audio(scaled_sample(square_wave(16'h0000), sustain));
        finish_test();

        start_test("adsr_release");
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_CTRL), 32'h0);
        polls = 0;
        bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS), rd);
        while (rd[2:0] != ADSR_IDLE && polls < POLL_LIMIT) begin
            polls++;
            bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS), rd);
        end
        check_equal("state", {29'h0, ADSR_IDLE}, {29'h0, rd[2:0]});
        check_equal("envelope", 32'h0, {16'h0, rd[31:16]});
        wait_frames(3);
        check_audio(scaled_sample(square_wave(16'h0000), 16'h0000));
        finish_test();

        $display("Summary: %0d tests pass, %0d tests fail, %0d errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* mmio_top.f */
+incdir+include
verilog/mmio_pkg.sv
verilog/mmio_controller.sv
verilog/mmio_gpo.sv
verilog/mmio_ddfs.sv
verilog/mmio_adsr.sv
verilog/i2s_tx.sv
verilog/mmio_top.sv
tb/mmio_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mmio_top_tb
FILELIST  ?= mmio_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
